//--- rtl/slurm16_defines.svh
// Word, address and bank widths for the slurm16 memory side, included by the package, RTL and testbench
`ifndef SLURM16_DEFINES_SVH
`define SLURM16_DEFINES_SVH

// Data word width of the CPU and of every memory word
`define SLURM16_BITS 16

// Word address width, the full 64K word space
`define SLURM16_ADDRESS_BITS 16

// Top address bits that pick one of the four banks
`define SLURM16_BANK_BITS 2

// Address bits inside one bank, giving 16K words per bank
`define SLURM16_BANK_ADDR_BITS 14

`endif

//--- rtl/slurm16_pkg.sv
// Sequencer state and memory request types, used by scoped name across the slurm16 memory side
`default_nettype none

`include "slurm16_defines.svh"

package slurm16_pkg;

	typedef enum logic [3:0] {
		cpust_halt            = 4'd0, // Halted, nothing is fetched until wake
		cpust_execute         = 4'd1, // Fetching and executing non-memory instructions
		cpust_wait_mem_ready1 = 4'd2, // First wait state after a fetch bank switch
		cpust_wait_mem_ready2 = 4'd3, // Waits for the grant on the new fetch bank
		cpust_execute_load    = 4'd4, // Executing a load
		cpust_wait_mem_load1  = 4'd5, // First wait state after a load bank switch
		cpust_wait_mem_load2  = 4'd6, // Waits for the grant on the new load bank
		cpust_execute_store   = 4'd7, // Executing a store
		cpust_wait_mem_store1 = 4'd8, // First wait state after a store bank switch
		cpust_wait_mem_store2 = 4'd9  // Waits for the grant on the new store bank
	} cpu_state_t;

	// One memory request as it travels from a master through the arbiter into the banks
	typedef struct packed {
		logic                             valid; // Request is present this cycle
		logic                             wr;    // High for a write, low for a read
		logic [`SLURM16_ADDRESS_BITS-1:0] addr;  // Word address, bank in the top bits
		logic [`SLURM16_BITS-1:0]         wdata; // Write data, ignored on reads
	} mem_req_t;

endpackage

`default_nettype wire

//--- rtl/slurm16_cpu_memory_interface.sv
// CPU side memory sequencer choosing fetch, load or store each cycle, with bank-switch waits and halt
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defines.svh"

module slurm16_cpu_memory_interface (
	input  wire                              CLK,
	input  wire                              RSTb,

	input  wire                              load_memory,        // Next access is a data load
	input  wire                              store_memory,       // Next access is a data store
	input  wire                              halt,               // Park the CPU
	input  wire                              wake,               // Leave the halt state

	input  wire [`SLURM16_ADDRESS_BITS-1:0]  pc,                 // Fetch address from the PC
	input  wire [`SLURM16_ADDRESS_BITS-1:0]  load_store_address, // Data address for loads and stores
	input  wire [`SLURM16_BITS-1:0]          store_memory_data,  // Data for the next store

	input  wire                              memory_ready,       // Grant level from the arbiter
	output slurm16_pkg::mem_req_t            memory_req,         // Request towards the arbiter

	output logic                             is_executing,       // Instruction may complete now
	output logic                             is_fetching,        // Steady fetch in one bank
	output logic                             memory_is_instruction, // Arriving data is an opcode
	output logic [`SLURM16_ADDRESS_BITS-1:0] memory_address_prev_plus_one // Return address
);

	localparam int ADDR_MSB = `SLURM16_ADDRESS_BITS - 1;

	slurm16_pkg::cpu_state_t state_q;
	slurm16_pkg::cpu_state_t state_d;

	logic [`SLURM16_ADDRESS_BITS-1:0] addr_q;          // Address on the bus
	logic [`SLURM16_ADDRESS_BITS-1:0] addr_d;          // Address chosen for the next cycle
	logic [`SLURM16_BITS-1:0]         wdata_q;         // Store data captured while executing
	logic [`SLURM16_ADDRESS_BITS-1:0] prev_plus_one_q; // Last cycle's address plus one
	logic                             instr_q;         // Tag of the last granted read

	logic executing;   // One of the three execute states
	logic fetch_state; // States whose reads are instruction fetches
	logic valid;
	logic wr;
	logic bank_switch; // Next address leaves the current bank

	function automatic logic has_bank_switch(
		input logic [`SLURM16_ADDRESS_BITS-1:0] a,
		input logic [`SLURM16_ADDRESS_BITS-1:0] b
	);
		has_bank_switch = a[ADDR_MSB -: `SLURM16_BANK_BITS] != b[ADDR_MSB -: `SLURM16_BANK_BITS];
	endfunction

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_q <= slurm16_pkg::cpust_wait_mem_ready1; // Start by opening the bank at 0
			addr_q  <= '0;
			instr_q <= 1'b0;
		end else begin
			state_q <= state_d;
			addr_q  <= addr_d;
			if (valid && !wr && memory_ready)
				instr_q <= fetch_state; // Data lands next cycle, tag it now
		end
	end

	always_ff @(posedge CLK) begin
		if (executing)
			wdata_q <= store_memory_data; // Store writes what was presented one cycle before
		prev_plus_one_q <= addr_q + 1'b1; // Return address for calls
	end

	assign executing = (state_q == slurm16_pkg::cpust_execute) ||
		(state_q == slurm16_pkg::cpust_execute_load) ||
		(state_q == slurm16_pkg::cpust_execute_store);

	assign fetch_state = (state_q == slurm16_pkg::cpust_execute) ||
		(state_q == slurm16_pkg::cpust_wait_mem_ready2);

	// Only an executing instruction may move the address
	always_comb begin
		addr_d = addr_q;
		if (executing) begin
			if (load_memory || store_memory)
				addr_d = load_store_address;
			else
				addr_d = pc;
		end
	end

	assign bank_switch = has_bank_switch(addr_q, addr_d);

	always_comb begin
		state_d = state_q;
		case (state_q)
			slurm16_pkg::cpust_halt: begin
				if (wake)
					state_d = slurm16_pkg::cpust_wait_mem_ready1;
			end
			slurm16_pkg::cpust_execute: begin
				if (halt)
					state_d = slurm16_pkg::cpust_halt;
				else if (load_memory)
					state_d = bank_switch ? slurm16_pkg::cpust_wait_mem_load1 :
						slurm16_pkg::cpust_execute_load;
				else if (store_memory)
					state_d = bank_switch ? slurm16_pkg::cpust_wait_mem_store1 :
						slurm16_pkg::cpust_execute_store;
				else if (bank_switch)
					state_d = slurm16_pkg::cpust_wait_mem_ready1; // Fetch jumps to another bank
			end
			slurm16_pkg::cpust_wait_mem_ready1:
				state_d = slurm16_pkg::cpust_wait_mem_ready2;
			slurm16_pkg::cpust_wait_mem_ready2: begin
				if (memory_ready)
					state_d = slurm16_pkg::cpust_execute;
			end
			slurm16_pkg::cpust_execute_load: begin
				if (!load_memory)
					state_d = bank_switch ? slurm16_pkg::cpust_wait_mem_ready1 :
						slurm16_pkg::cpust_execute;
				else if (bank_switch)
					state_d = slurm16_pkg::cpust_wait_mem_load1; // Back to back load elsewhere
			end
			slurm16_pkg::cpust_wait_mem_load1:
				state_d = slurm16_pkg::cpust_wait_mem_load2;
			slurm16_pkg::cpust_wait_mem_load2: begin
				if (memory_ready)
					state_d = slurm16_pkg::cpust_execute_load;
			end
			slurm16_pkg::cpust_execute_store: begin
				if (!store_memory)
					state_d = bank_switch ? slurm16_pkg::cpust_wait_mem_ready1 :
						slurm16_pkg::cpust_execute;
				else if (bank_switch)
					state_d = slurm16_pkg::cpust_wait_mem_store1;
			end
			slurm16_pkg::cpust_wait_mem_store1:
				state_d = slurm16_pkg::cpust_wait_mem_store2;
			slurm16_pkg::cpust_wait_mem_store2: begin
				if (memory_ready)
					state_d = slurm16_pkg::cpust_execute_store;
			end
			default:
				state_d = slurm16_pkg::cpust_halt; // Unused codes park the CPU
		endcase
	end

	// The first wait state of each pair keeps the bus idle while the bank changes
	always_comb begin
		valid = 1'b0;
		wr    = 1'b0;
		case (state_q)
			slurm16_pkg::cpust_execute,
			slurm16_pkg::cpust_wait_mem_ready2,
			slurm16_pkg::cpust_execute_load,
			slurm16_pkg::cpust_wait_mem_load2:
				valid = 1'b1;
			slurm16_pkg::cpust_execute_store,
			slurm16_pkg::cpust_wait_mem_store2: begin
				valid = 1'b1;
				wr    = 1'b1;
			end
			default: begin
				valid = 1'b0;
				wr    = 1'b0;
			end
		endcase
	end

	always_comb begin
		memory_req.valid = valid;
		memory_req.wr    = wr;
		memory_req.addr  = addr_q;
		memory_req.wdata = wdata_q;
	end

	assign is_executing = executing;
	assign is_fetching  = (state_q == slurm16_pkg::cpust_execute) &&
		(state_d == slurm16_pkg::cpust_execute);
	assign memory_is_instruction        = instr_q;
	assign memory_address_prev_plus_one = prev_plus_one_q;

endmodule

`default_nettype wire

//--- rtl/slurm16_memory_arbiter.sv
// Per-cycle arbiter sharing the banked memory between the CPU and one external master
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defines.svh"

module slurm16_memory_arbiter (
	input  wire                   CLK,
	input  wire                   RSTb,

	input  wire slurm16_pkg::mem_req_t cpu_req, // Request from the CPU sequencer
	input  wire slurm16_pkg::mem_req_t ext_req, // Request from the external master

	output logic                  cpu_ready,    // CPU access is done when valid is also high
	output logic                  ext_ready,    // External access is done when valid is also high

	output slurm16_pkg::mem_req_t port_a,       // CPU side into the memory
	output slurm16_pkg::mem_req_t port_b        // External side into the memory
);

	localparam int ADDR_MSB = `SLURM16_ADDRESS_BITS - 1;

	logic [`SLURM16_BANK_BITS-1:0] cpu_bank; // Bank the CPU addresses
	logic [`SLURM16_BANK_BITS-1:0] ext_bank; // Bank the external master addresses
	logic                          clash;    // Both masters want the same bank
	logic                          cpu_grant;
	logic                          ext_grant;

	assign cpu_bank = cpu_req.addr[ADDR_MSB -: `SLURM16_BANK_BITS];
	assign ext_bank = ext_req.addr[ADDR_MSB -: `SLURM16_BANK_BITS];

	// A clash only matters when the external master actually asks
	assign clash = ext_req.valid && (cpu_bank == ext_bank);

	// The external master always wins, so it is ready whenever it asks
	assign ext_ready = ext_req.valid;
	assign cpu_ready = !clash;

	assign ext_grant = ext_req.valid;
	assign cpu_grant = cpu_req.valid && !clash;

	// Requests pass through unchanged apart from valid, which carries the grant
	always_comb begin
		port_a       = cpu_req;
		port_a.valid = cpu_grant;
		port_b       = ext_req;
		port_b.valid = ext_grant;
	end

endmodule

`default_nettype wire

//--- rtl/slurm16_banked_memory.sv
// Four single-port synchronous RAM banks behind two request ports, with read data one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defines.svh"

module slurm16_banked_memory (
	input  wire                        CLK,

	input  wire slurm16_pkg::mem_req_t port_a, // CPU side, already granted
	input  wire slurm16_pkg::mem_req_t port_b, // External side, already granted

	output logic [`SLURM16_BITS-1:0]   rdata_a,
	output logic [`SLURM16_BITS-1:0]   rdata_b
);

	localparam int ADDR_MSB   = `SLURM16_ADDRESS_BITS - 1;
	localparam int NUM_BANKS  = 1 << `SLURM16_BANK_BITS;
	localparam int BANK_WORDS = 1 << `SLURM16_BANK_ADDR_BITS;

	slurm16_pkg::mem_req_t    port [2];         // Ports as an array so both share one path
	logic [`SLURM16_BITS-1:0] bank_q [NUM_BANKS]; // Registered read word of each bank
	logic [`SLURM16_BITS-1:0] rdata [2];

	assign port[0] = port_a;
	assign port[1] = port_b;
	assign rdata_a = rdata[0];
	assign rdata_b = rdata[1];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		localparam logic [`SLURM16_BANK_BITS-1:0] BANK_ID = b;

		logic [`SLURM16_BITS-1:0] ram [BANK_WORDS];
		logic [`SLURM16_BITS-1:0] q;
		logic                     hit_a;
		logic                     hit_b;
		slurm16_pkg::mem_req_t    req;

		assign hit_a = port_a.valid && (port_a.addr[ADDR_MSB -: `SLURM16_BANK_BITS] == BANK_ID);
		assign hit_b = port_b.valid && (port_b.addr[ADDR_MSB -: `SLURM16_BANK_BITS] == BANK_ID);
		assign req   = hit_a ? port_a : port_b; // Arbiter never lets both hit one bank

		always_ff @(posedge CLK) begin
			if (hit_a || hit_b) begin
				if (req.wr)
					ram[req.addr[`SLURM16_BANK_ADDR_BITS-1:0]] <= req.wdata;
				else
					q <= ram[req.addr[`SLURM16_BANK_ADDR_BITS-1:0]];
			end
		end

		assign bank_q[b] = q;
	end

	// Each port remembers which bank it read from and holds its data between reads
	for (genvar p = 0; p < 2; p++) begin : g_port
		logic                          rd_q;
		logic [`SLURM16_BANK_BITS-1:0] bank_sel_q;
		logic [`SLURM16_BITS-1:0]      hold_q;

		always_ff @(posedge CLK) begin
			rd_q       <= port[p].valid && !port[p].wr;
			bank_sel_q <= port[p].addr[ADDR_MSB -: `SLURM16_BANK_BITS];
			hold_q     <= rdata[p];
		end

		assign rdata[p] = rd_q ? bank_q[bank_sel_q] : hold_q;
	end

endmodule

`default_nettype wire

//--- rtl/slurm16_mem_subsystem.sv
// Top of the slurm16 memory side, joining the CPU sequencer, arbiter and banked memory
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defines.svh"

module slurm16_mem_subsystem (
	input  wire                              CLK,
	input  wire                              RSTb,

	// CPU control, played by the rest of the core
	input  wire                              load_memory,
	input  wire                              store_memory,
	input  wire                              halt,
	input  wire                              wake,
	input  wire [`SLURM16_ADDRESS_BITS-1:0]  pc,
	input  wire [`SLURM16_ADDRESS_BITS-1:0]  load_store_address,
	input  wire [`SLURM16_BITS-1:0]          store_memory_data,

	// External master such as a DMA or display engine
	input  wire slurm16_pkg::mem_req_t       ext_req,
	output logic                             ext_ready,
	output logic [`SLURM16_BITS-1:0]         ext_rdata,

	// CPU bus as the arbiter sees it, brought out for monitoring
	output slurm16_pkg::mem_req_t            cpu_req,
	output logic                             cpu_ready,
	output logic [`SLURM16_BITS-1:0]         cpu_rdata,

	output logic                             is_executing,
	output logic                             is_fetching,
	output logic                             memory_is_instruction,
	output logic [`SLURM16_ADDRESS_BITS-1:0] memory_address_prev_plus_one
);

	slurm16_pkg::mem_req_t port_a; // Granted CPU request
	slurm16_pkg::mem_req_t port_b; // Granted external request

	slurm16_cpu_memory_interface i_cpu_mem_if (
		.CLK                          (CLK),
		.RSTb                         (RSTb),
		.load_memory                  (load_memory),
		.store_memory                 (store_memory),
		.halt                         (halt),
		.wake                         (wake),
		.pc                           (pc),
		.load_store_address           (load_store_address),
		.store_memory_data            (store_memory_data),
		.memory_ready                 (cpu_ready),
		.memory_req                   (cpu_req),
		.is_executing                 (is_executing),
		.is_fetching                  (is_fetching),
		.memory_is_instruction        (memory_is_instruction),
		.memory_address_prev_plus_one (memory_address_prev_plus_one)
	);

	slurm16_memory_arbiter i_arbiter (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.cpu_req   (cpu_req),
		.ext_req   (ext_req),
		.cpu_ready (cpu_ready),
		.ext_ready (ext_ready),
		.port_a    (port_a),
		.port_b    (port_b)
	);

	slurm16_banked_memory i_memory (
		.CLK     (CLK),
		.port_a  (port_a),
		.port_b  (port_b),
		.rdata_a (cpu_rdata),
		.rdata_b (ext_rdata)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Clock and reset source for the slurm16 memory testbench, 20 ns period and an 8 cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK; // Half of the 20 ns period
	end

	initial begin
		RSTb = 1'b0;
		repeat (8) @(posedge CLK); // Reset is seen by eight rising edges
		RSTb <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/tb_slurm16_mem.sv
// Testbench for the slurm16 memory side, plays the CPU core and an external master against assertions
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defines.svh"

module tb_slurm16_mem;

	localparam int AW      = `SLURM16_ADDRESS_BITS;
	localparam int DW      = `SLURM16_BITS;
	localparam int BB      = `SLURM16_BANK_BITS;
	localparam int TIMEOUT = 60; // Cycles that any single wait may last

	logic CLK, RSTb;
	logic load_memory, store_memory, halt, wake;
	logic [AW-1:0] pc, load_store_address, memory_address_prev_plus_one;
	logic [DW-1:0] store_memory_data, ext_rdata, cpu_rdata;
	slurm16_pkg::mem_req_t ext_req, cpu_req;
	logic ext_ready, cpu_ready, is_executing, is_fetching, memory_is_instruction;

	logic [DW-1:0] ref_mem [logic [AW-1:0]]; // Reference memory, only written words exist
	logic          rst_prev_q = 1'b1;        // RSTb at the previous edge
	int            edge_count_q = 0;
	logic [AW-1:0] prev_addr_q;              // Bus address one cycle back
	logic          chosen_load_q;            // load_memory when the bus address was chosen
	logic [DW-1:0] exp_wdata_q;              // Store data presented one cycle back
	logic          cpu_rd_q, cpu_rd_known_q, cpu_rd_fetch_q, ext_rd_q, ext_rd_known_q;
	logic [DW-1:0] cpu_rd_exp_q, ext_rd_exp_q; // Words expected on the cycle after a read
	int            gap_q;                    // Cycles with is_executing low since the last valid
	logic [BB-1:0] last_bank_q;
	logic          have_bank_q, steady_q, parked_q;

	wire          cpu_done = cpu_req.valid && cpu_ready;
	wire          ext_done = ext_req.valid && ext_ready;
	wire [BB-1:0] cpu_bank = cpu_req.addr[AW-1 -: BB];
	wire [BB-1:0] ext_bank = ext_req.addr[AW-1 -: BB];

	tb_clock_gen i_clock_gen (.*);
	slurm16_mem_subsystem i_dut (.*); // Port names match the testbench signals one to one

	task automatic stop_failed();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic value_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %s expected %h actual %h (state %s)", test, expected, actual,
			i_dut.i_cpu_mem_if.state_q.name());
		stop_failed();
	endtask

	// Every address bit moves the word, so a wrong bank or offset shows
	function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] addr);
		fill_word = (addr * 16'h9e37) ^ {addr[7:0], addr[15:8]};
	endfunction

	// Samples on the falling edge, where all outputs have settled
	task automatic wait_until(input int which, input string what,
		input logic [AW-1:0] addr = '0, input logic wr = 1'b0);
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge CLK);
			if ((which == 0 && RSTb) || (which == 1 && cpu_req.valid) ||
				(which == 2 && is_executing) || (which == 3 && is_fetching) ||
				(which == 4 && cpu_done && cpu_req.addr == addr && cpu_req.wr == wr) ||
				(which == 5 && ext_ready))
				return;
		end
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
		stop_failed();
	endtask

	task automatic ext_access(input logic wr, input logic [AW-1:0] addr, input logic [DW-1:0] data);
		@(posedge CLK);
		ext_req <= '{valid: 1'b1, wr: wr, addr: addr, wdata: data};
		wait_until(5, "external master grant"); // Done at the next rising edge
	endtask

	// The core asks for one load or store and drops the request once it is done
	task automatic cpu_access(input logic wr, input logic [AW-1:0] addr, input logic [DW-1:0] data);
		wait_until(2, "an execute state");
		@(posedge CLK);
		load_memory        <= !wr;
		store_memory       <= wr;
		load_store_address <= addr;
		store_memory_data  <= data;
		wait_until(4, wr ? "store grant" : "load grant", addr, wr);
		@(posedge CLK);
		load_memory  <= 1'b0;
		store_memory <= 1'b0;
	endtask

	always @(posedge CLK) begin
		rst_prev_q   <= RSTb;
		edge_count_q <= edge_count_q + 1;
		prev_addr_q  <= cpu_req.addr;
		exp_wdata_q  <= store_memory_data; // A store writes the data of the cycle before
		if (is_executing)
			chosen_load_q <= load_memory; // Next cycle's address is picked on this edge
		cpu_rd_q       <= RSTb && cpu_done && !cpu_req.wr;
		cpu_rd_fetch_q <= !chosen_load_q;
		cpu_rd_known_q <= ref_mem.exists(cpu_req.addr) != 0;
		cpu_rd_exp_q   <= ref_mem.exists(cpu_req.addr) ? ref_mem[cpu_req.addr] : '0;
		ext_rd_q       <= RSTb && ext_done && !ext_req.wr;
		ext_rd_known_q <= ref_mem.exists(ext_req.addr) != 0;
		ext_rd_exp_q   <= ref_mem.exists(ext_req.addr) ? ref_mem[ext_req.addr] : '0;
		if (cpu_req.valid) begin
			gap_q       <= 0;
			last_bank_q <= cpu_bank;
			have_bank_q <= 1'b1;
		end else if (!is_executing)
			gap_q <= gap_q + 1;
		if (halt && is_executing && !load_memory && !store_memory)
			parked_q <= 1'b1; // Halt only counts in the plain execute state
		else if (wake)
			parked_q <= 1'b0;
		if (!RSTb) begin
			chosen_load_q <= 1'b0;
			have_bank_q   <= 1'b0;
			gap_q         <= 0;
			parked_q      <= 1'b0;
		end
		// Reads above saw the old words, same-cycle writes land after them
		if (RSTb && cpu_done && cpu_req.wr)
			ref_mem[cpu_req.addr] = cpu_req.wdata;
		if (RSTb && ext_done && ext_req.wr)
			ref_mem[ext_req.addr] = ext_req.wdata;
	end

	a_reset: assert property (@(posedge CLK) !rst_prev_q |->
		!cpu_req.valid && !is_executing && !is_fetching)
		else value_mismatch("reset quiet", 0, {cpu_req.valid, is_executing, is_fetching});
	a_cpu_rdata: assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_rd_q && cpu_rd_known_q |-> cpu_rdata == cpu_rd_exp_q)
		else value_mismatch("cpu read data", cpu_rd_exp_q, cpu_rdata);
	a_instr_tag: assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_rd_q |-> memory_is_instruction == cpu_rd_fetch_q)
		else value_mismatch("instruction tag", cpu_rd_fetch_q, memory_is_instruction);
	a_store_data: assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_done && cpu_req.wr |-> cpu_req.wdata == exp_wdata_q)
		else value_mismatch("store data", exp_wdata_q, cpu_req.wdata);
	a_bank_gap: assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_req.valid && have_bank_q && cpu_bank != last_bank_q |->
		gap_q + (is_executing ? 0 : 1) >= 2)
		else value_mismatch("bank switch gap", 2, gap_q + (is_executing ? 0 : 1));
	a_steady: assert property (@(posedge CLK) disable iff (!RSTb)
		steady_q |-> is_executing && is_fetching)
		else value_mismatch("steady fetch", 2'b11, {is_executing, is_fetching});
	a_clash: assert property (@(posedge CLK) disable iff (!RSTb)
		ext_req.valid && ext_bank == cpu_bank |-> !cpu_ready && ext_ready)
		else value_mismatch("bank clash ready", 2'b01, {cpu_ready, ext_ready});
	a_share: assert property (@(posedge CLK) disable iff (!RSTb)
		ext_req.valid && ext_bank != cpu_bank |-> cpu_ready && ext_ready)
		else value_mismatch("shared ready", 2'b11, {cpu_ready, ext_ready});
	a_ext_rdata: assert property (@(posedge CLK) disable iff (!RSTb)
		ext_rd_q && ext_rd_known_q |-> ext_rdata == ext_rd_exp_q)
		else value_mismatch("external read data", ext_rd_exp_q, ext_rdata);
	a_parked: assert property (@(posedge CLK) disable iff (!RSTb)
		parked_q |-> !cpu_req.valid)
		else value_mismatch("halt parks bus", 0, cpu_req.valid);
	a_ret_addr: assert property (@(posedge CLK) edge_count_q >= 2 |->
		memory_address_prev_plus_one == prev_addr_q + AW'(1))
		else value_mismatch("return address", prev_addr_q + AW'(1), memory_address_prev_plus_one);

	initial begin
		logic [AW-1:0] addrs [8];
		logic [AW-1:0] a;
		int i;
		void'($urandom(32'h7b88));
		load_memory        <= 1'b0;
		store_memory       <= 1'b0;
		halt               <= 1'b0;
		wake               <= 1'b0;
		pc                 <= '0;
		load_store_address <= '0;
		store_memory_data  <= '0;
		ext_req            <= '0;
		steady_q           <= 1'b0;
		wait_until(0, "reset release");
		wait_until(1, "the first fetch request");
		// First sixteen words of each bank, written while the CPU fetches from bank 0
		for (i = 0; i < 64; i++) begin
			a = {i[5:4], 10'h000, i[3:0]};
			ext_access(1'b1, a, fill_word(a));
		end
		@(posedge CLK) ext_req.valid <= 1'b0;
		@(posedge CLK) pc <= 16'h4000; // Jump into bank 1
		wait_until(3, "steady fetch in bank 1");
		for (i = 1; i < 12; i++) begin
			@(posedge CLK);
			pc       <= 16'h4000 + AW'(i);
			steady_q <= 1'b1;
		end
		@(posedge CLK) steady_q <= 1'b0;
		for (i = 0; i < 8; i++) begin
			addrs[i] = {i[1:0], 14'($urandom)}; // Two stores into each bank
			cpu_access(1'b1, addrs[i], 16'($urandom));
		end
		for (i = 0; i < 8; i++)
			cpu_access(1'b0, addrs[i], '0);
		wait_until(3, "fetch before external traffic");
		// Bank 1 clashes with the CPU fetch, bank 2 runs beside it
		for (i = 0; i < 8; i++) begin
			addrs[i] = {(i[0] ? 2'd2 : 2'd1), 14'($urandom)};
			ext_access(1'b1, addrs[i], 16'($urandom));
		end
		for (i = 0; i < 8; i++)
			ext_access(1'b0, addrs[i], '0);
		@(posedge CLK) ext_req.valid <= 1'b0;
		wait_until(3, "fetch before halt");
		@(posedge CLK) halt <= 1'b1;
		@(posedge CLK) halt <= 1'b0;
		repeat (6) @(posedge CLK);
		wake <= 1'b1;
		@(posedge CLK) wake <= 1'b0;
		wait_until(3, "fetch after wake");
		repeat (4) @(posedge CLK);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- slurm16_mem.f
+incdir+rtl
rtl/slurm16_pkg.sv
rtl/slurm16_cpu_memory_interface.sv
rtl/slurm16_memory_arbiter.sv
rtl/slurm16_banked_memory.sv
rtl/slurm16_mem_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_slurm16_mem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the slurm16 memory testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
	-f slurm16_mem.f \
	--top-module tb_slurm16_mem

# A failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/Vtb_slurm16_mem
